// ==== source/zap_pkg.sv ====
package zap_pkg;

        // Word and field types.
        typedef logic [31:0] instr_t;
        typedef logic [34:0] arm_instr_t;
        typedef logic [31:0] cpsr_t;
        typedef logic [3:0]  cond_t;
        typedef logic [23:0] offset_t;
        typedef logic [3:0]  reg_idx_t;

        // Class of a decoded operation.
        typedef enum logic [2:0]
        {
                OP_BRANCH,
                OP_BX,
                OP_SWI,
                OP_UND,
                OP_OTHER
        } op_class_t;

        // Thumb bit position in the status word.
        localparam int CPSR_T = 5;

        localparam cond_t COND_AL = 4'hE;

        // Buffer depth, equal to the fetch side credit count.
        localparam int FETCH_DEPTH = 4;

        localparam int CREDIT_W = 3;
        localparam logic [CREDIT_W-1:0] ISSUE_CREDITS = 3'd4;

        // Thumb patterns, matched as (halfword & MASK) == PAT.
        localparam logic [15:0] T_SWI_PAT   = 16'b1101_1111_0000_0000;
        localparam logic [15:0] T_SWI_MASK  = 16'b1111_1111_0000_0000;
        localparam logic [15:0] T_BCOND_PAT  = 16'b1101_0000_0000_0000;
        localparam logic [15:0] T_BCOND_MASK = 16'b1111_0000_0000_0000;
        localparam logic [15:0] T_B_PAT     = 16'b1110_0000_0000_0000;
        localparam logic [15:0] T_B_MASK    = 16'b1111_1000_0000_0000;
        localparam logic [15:0] T_BL_PAT    = 16'b1111_0000_0000_0000;
        localparam logic [15:0] T_BL_MASK   = 16'b1111_0000_0000_0000;
        localparam logic [15:0] T_BX_PAT    = 16'b0100_0111_0000_0000;
        localparam logic [15:0] T_BX_MASK   = 16'b1111_1111_1000_0000;

endpackage

// ==== source/fetch_buffer.sv ====
`timescale 1ns/1ps

module fetch_buffer
(
        input  logic            i_clk,
        input  logic            i_arst_n,

        // Fetch side.
        input  logic            i_instr_valid,
        input  zap_pkg::instr_t i_instr,

        // Release of the head word.
        input  logic            i_pop,

        output logic            o_head_valid,
        output zap_pkg::instr_t o_head,
        output logic            o_fetch_credit
);

        logic [$clog2(zap_pkg::FETCH_DEPTH)-1:0]   wr_ptr;
        logic [$clog2(zap_pkg::FETCH_DEPTH)-1:0]   rd_ptr;
        logic [$clog2(zap_pkg::FETCH_DEPTH+1)-1:0] count;
        zap_pkg::instr_t                           mem [zap_pkg::FETCH_DEPTH];
        logic                                      wr;
        logic                                      rd;

        // A full buffer drops the write; the fetch side never does this.
        assign wr = i_instr_valid && (count != zap_pkg::FETCH_DEPTH);
        assign rd = i_pop && (count != '0);

        assign o_head_valid = (count != '0);
        assign o_head       = mem[rd_ptr];

        always_ff @(posedge i_clk)
        begin
                if (wr)
                begin
                        mem[wr_ptr] <= i_instr;
                end
        end

        always_ff @(posedge i_clk or negedge i_arst_n)
        begin
                if (!i_arst_n)
                begin
                        wr_ptr         <= '0;
                        rd_ptr         <= '0;
                        count          <= '0;
                        o_fetch_credit <= 1'b0;
                end
                else
                begin
                        // Pointers wrap naturally, depth is a power of two.
                        if (wr)
                                wr_ptr <= wr_ptr + 1'b1;
                        if (rd)
                                rd_ptr <= rd_ptr + 1'b1;
                        case ({wr, rd})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                        // One credit back per released word.
                        o_fetch_credit <= rd;
                end
        end

endmodule

// ==== source/decode_thumb.sv ====
`timescale 1ns/1ps

module decode_thumb
(
        input  logic                i_clk,
        input  logic                i_arst_n,

        // Head of the fetch buffer.
        input  logic                i_head_valid,
        input  zap_pkg::instr_t     i_head,
        input  logic                i_pop,

        input  zap_pkg::cpsr_t      i_cpsr,

        // ARM form toward the ARM decoder.
        output zap_pkg::arm_instr_t o_instr,
        output logic                o_valid,
        output logic                o_und
);

        logic [15:0]      hw;
        logic             thumb;
        logic             bl_first;
        logic [10:0]      bl_hi;
        zap_pkg::offset_t bl_off;

        assign hw    = i_head[15:0];
        assign thumb = i_cpsr[zap_pkg::CPSR_T];

        // Upper half of the BL offset joined with the lower half.
        assign bl_off = {{2{bl_hi[10]}}, bl_hi, hw[10:0]};

        always_comb
        begin
                // ARM mode passes the word on unchanged.
                o_instr  = {3'b000, i_head};
                o_valid  = i_head_valid;
                o_und    = 1'b0;
                bl_first = 1'b0;

                if (thumb)
                begin
                        // SWI comes first, condition 1111 overlaps B<cond>.
                        if ((hw & zap_pkg::T_SWI_MASK) == zap_pkg::T_SWI_PAT)
                        begin
                                o_instr = {3'b000, zap_pkg::COND_AL, 4'b1111,
                                           16'd0, hw[7:0]};
                        end
                        else if ((hw & zap_pkg::T_BCOND_MASK) == zap_pkg::T_BCOND_PAT)
                        begin
                                // Keeps its own condition.
                                o_instr = {1'b1, 2'b00, hw[11:8], 3'b101, 1'b0,
                                           {{16{hw[7]}}, hw[7:0]}};
                        end
                        else if ((hw & zap_pkg::T_B_MASK) == zap_pkg::T_B_PAT)
                        begin
                                o_instr = {1'b1, 2'b00, zap_pkg::COND_AL, 3'b101, 1'b0,
                                           {{13{hw[10]}}, hw[10:0]}};
                        end
                        else if ((hw & zap_pkg::T_BL_MASK) == zap_pkg::T_BL_PAT)
                        begin
                                if (!hw[11])
                                begin
                                        // First half, no operation of its own.
                                        bl_first = 1'b1;
                                        o_valid  = 1'b0;
                                end
                                else
                                begin
                                        o_instr = {1'b1, 2'b00, zap_pkg::COND_AL, 3'b101,
                                                   1'b1, bl_off};
                                end
                        end
                        else if ((hw & zap_pkg::T_BX_MASK) == zap_pkg::T_BX_PAT)
                        begin
                                o_instr = {3'b000, zap_pkg::COND_AL, 24'h12FFF1, hw[6:3]};
                        end
                        else
                        begin
                                o_und = 1'b1;
                        end
                end
        end

        // Upper offset, taken when a first half leaves the buffer.
        always_ff @(posedge i_clk or negedge i_arst_n)
        begin
                if (!i_arst_n)
                        bl_hi <= '0;
                else if (i_pop && i_head_valid && bl_first)
                        bl_hi <= hw[10:0];
        end

endmodule

// ==== source/decode_arm.sv ====
`timescale 1ns/1ps

module decode_arm
(
        input  logic                i_clk,
        input  logic                i_arst_n,

        // From the Thumb converter.
        input  zap_pkg::arm_instr_t i_instr,
        input  logic                i_valid,
        input  logic                i_und,
        input  logic                i_head_valid,

        // Credit return from issue.
        input  logic                i_issue_credit,

        output logic                o_pop,

        // Decoded operation.
        output logic                o_op_valid,
        output zap_pkg::op_class_t  o_op_class,
        output zap_pkg::cond_t      o_op_cond,
        output logic                o_op_link,
        output logic                o_op_half,
        output zap_pkg::offset_t    o_op_offset,
        output zap_pkg::reg_idx_t   o_op_rm,
        output logic [23:0]         o_op_imm,
        output zap_pkg::instr_t     o_op_word
);

        logic [zap_pkg::CREDIT_W-1:0] credits;
        logic                         take;
        zap_pkg::op_class_t           cls;

        // A word without an operation may leave even with no credits.
        assign o_pop = i_head_valid && ((credits != '0) || !i_valid);
        assign take  = o_pop && i_valid;

        always_comb
        begin
                if (i_und)
                        cls = zap_pkg::OP_UND;
                else if (i_instr[27:25] == 3'b101)
                        cls = zap_pkg::OP_BRANCH;
                else if (i_instr[27:4] == 24'h12FFF1)
                        cls = zap_pkg::OP_BX;
                else if (i_instr[27:24] == 4'b1111)
                        cls = zap_pkg::OP_SWI;
                else
                        cls = zap_pkg::OP_OTHER;
        end

        always_ff @(posedge i_clk or negedge i_arst_n)
        begin
                if (!i_arst_n)
                begin
                        o_op_valid <= 1'b0;
                        credits    <= zap_pkg::ISSUE_CREDITS;
                end
                else
                begin
                        o_op_valid <= take;
                        case ({take, i_issue_credit})
                                2'b10:   credits <= credits - 1'b1;
                                2'b01:   credits <= credits + 1'b1;
                                default: credits <= credits;
                        endcase
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (take)
                begin
                        o_op_class  <= cls;
                        o_op_cond   <= i_instr[31:28];
                        o_op_link   <= (cls == zap_pkg::OP_BRANCH) && i_instr[24];
                        // Halfword flag from the converter.
                        o_op_half   <= i_instr[34];
                        o_op_offset <= i_instr[23:0];
                        o_op_rm     <= i_instr[3:0];
                        o_op_imm    <= i_instr[23:0];
                        o_op_word   <= i_instr[31:0];
                end
        end

endmodule

// ==== source/decode_frontend.sv ====
`timescale 1ns/1ps

module decode_frontend
(
        input  logic               i_clk,
        input  logic               i_arst_n,

        input  logic               i_instr_valid,
        input  zap_pkg::instr_t    i_instr,
        input  zap_pkg::cpsr_t     i_cpsr,
        input  logic               i_issue_credit,

        output logic               o_fetch_credit,

        output logic               o_op_valid,
        output zap_pkg::op_class_t o_op_class,
        output zap_pkg::cond_t     o_op_cond,
        output logic               o_op_link,
        output logic               o_op_half,
        output zap_pkg::offset_t   o_op_offset,
        output zap_pkg::reg_idx_t  o_op_rm,
        output logic [23:0]        o_op_imm,
        output zap_pkg::instr_t    o_op_word
);

        logic                head_valid;
        zap_pkg::instr_t     head;
        logic                pop;
        zap_pkg::arm_instr_t thumb_instr;
        logic                thumb_valid;
        logic                thumb_und;

        fetch_buffer fetch_buffer_i
        (
                .i_clk          (i_clk),
                .i_arst_n       (i_arst_n),
                .i_instr_valid  (i_instr_valid),
                .i_instr        (i_instr),
                .i_pop          (pop),
                .o_head_valid   (head_valid),
                .o_head         (head),
                .o_fetch_credit (o_fetch_credit)
        );

        // Converter sits in series ahead of the ARM decoder.
        decode_thumb decode_thumb_i
        (
                .i_clk        (i_clk),
                .i_arst_n     (i_arst_n),
                .i_head_valid (head_valid),
                .i_head       (head),
                .i_pop        (pop),
                .i_cpsr       (i_cpsr),
                .o_instr      (thumb_instr),
                .o_valid      (thumb_valid),
                .o_und        (thumb_und)
        );

        decode_arm decode_arm_i
        (
                .i_clk          (i_clk),
                .i_arst_n       (i_arst_n),
                .i_instr        (thumb_instr),
                .i_valid        (thumb_valid),
                .i_und          (thumb_und),
                .i_head_valid   (head_valid),
                .i_issue_credit (i_issue_credit),
                .o_pop          (pop),
                .o_op_valid     (o_op_valid),
                .o_op_class     (o_op_class),
                .o_op_cond      (o_op_cond),
                .o_op_link      (o_op_link),
                .o_op_half      (o_op_half),
                .o_op_offset    (o_op_offset),
                .o_op_rm        (o_op_rm),
                .o_op_imm       (o_op_imm),
                .o_op_word      (o_op_word)
        );

endmodule

// ==== tests/decode_frontend_chk.sv ====
`timescale 1ns/1ps

module buffer_credit_chk
(
        input logic       i_clk,
        input logic       i_arst_n,
        input logic       i_instr_valid,
        input logic       i_pop,
        input logic       i_head_valid,
        input logic [$clog2(zap_pkg::FETCH_DEPTH+1)-1:0] i_count,
        input logic       i_fetch_credit
);

        // The fetch side holds no credit when the buffer is full.
        no_write_when_full: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                !(i_instr_valid && (i_count == zap_pkg::FETCH_DEPTH)))
                else $error("write into a full fetch buffer");

        // Every credit pulse follows a release one cycle earlier.
        credit_after_pop: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                i_fetch_credit |-> $past(i_pop && i_head_valid))
                else $error("fetch credit without a release in the cycle before");

        occupancy_bound: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                i_count <= zap_pkg::FETCH_DEPTH)
                else $error("fetch buffer occupancy above its depth");

endmodule

bind fetch_buffer buffer_credit_chk buffer_credit_chk_i
(
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_instr_valid  (i_instr_valid),
        .i_pop          (i_pop),
        .i_head_valid   (o_head_valid),
        .i_count        (count),
        .i_fetch_credit (o_fetch_credit)
);

// ==== tests/decode_frontend_tb.sv ====
`timescale 1ns/1ps

module decode_frontend_tb;

        typedef struct packed
        {
                zap_pkg::op_class_t cls;
                zap_pkg::cond_t     cond;
                logic               link;
                logic               half;
                zap_pkg::offset_t   offset;
                zap_pkg::reg_idx_t  rm;
                logic [23:0]        imm;
                zap_pkg::instr_t    word;
        } exp_op_t;

        logic               i_clk;
        logic               i_arst_n;
        logic               i_instr_valid;
        zap_pkg::instr_t    i_instr;
        zap_pkg::cpsr_t     i_cpsr;
        logic               i_issue_credit;
        logic               o_fetch_credit;
        logic               o_op_valid;
        zap_pkg::op_class_t o_op_class;
        zap_pkg::cond_t     o_op_cond;
        logic               o_op_link;
        logic               o_op_half;
        zap_pkg::offset_t   o_op_offset;
        zap_pkg::reg_idx_t  o_op_rm;
        logic [23:0]        o_op_imm;
        zap_pkg::instr_t    o_op_word;

        exp_op_t         exp_q[$];
        zap_pkg::instr_t seg_words[$];
        zap_pkg::instr_t rand_words[32];
        logic [10:0]     model_bl_hi;
        integer          seed = 32'hf0484222;
        int              fetch_credits;
        int              issue_credits;
        int              words_sent;
        int              credits_back;
        int              cycles;
        int              cycle_limit;

        decode_frontend decode_frontend_i (.*);

        always #2 i_clk = ~i_clk;

        task automatic fail_now(input string msg);
                $display("%s", msg);
                $display("RESULT: FAIL");
                $fatal(1);
        endtask

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                assert (got === exp)
                else fail_now($sformatf("Error: %s got %h expected %h", name, got, exp));
        endtask

        // Expected operation for one word; returns 0 when the word makes none.
        function automatic logic ref_decode(input zap_pkg::instr_t w, input logic thumb,
                                            inout logic [10:0] bl_hi, output exp_op_t op);
                logic [15:0]     hw;
                zap_pkg::instr_t arm;
                logic            half;
                logic            und;
                logic [21:0]     bl_off;
                hw   = w[15:0];
                arm  = w;
                half = 1'b0;
                und  = 1'b0;
                op   = '0;
                if (thumb)
                begin
                        if (hw[15:8] == 8'hDF)
                                arm = {zap_pkg::COND_AL, 4'hF, 16'h0, hw[7:0]};
                        else if (hw[15:12] == 4'hD)
                        begin
                                arm  = {hw[11:8], 4'b1010, {16{hw[7]}}, hw[7:0]};
                                half = 1'b1;
                        end
                        else if (hw[15:11] == 5'b11100)
                        begin
                                arm  = {zap_pkg::COND_AL, 4'b1010, {13{hw[10]}}, hw[10:0]};
                                half = 1'b1;
                        end
                        else if (hw[15:11] == 5'b11110)
                        begin
                                bl_hi = hw[10:0];
                                return 1'b0;
                        end
                        else if (hw[15:11] == 5'b11111)
                        begin
                                bl_off = {bl_hi, hw[10:0]};
                                arm    = {zap_pkg::COND_AL, 4'b1011, {2{bl_off[21]}}, bl_off};
                                half   = 1'b1;
                        end
                        else if (hw[15:7] == 9'b010001110)
                                arm = {zap_pkg::COND_AL, 24'h12FFF1, hw[6:3]};
                        else
                                und = 1'b1;
                end
                if (und)
                        op.cls = zap_pkg::OP_UND;
                else if (arm[27:25] == 3'b101)
                        op.cls = zap_pkg::OP_BRANCH;
                else if (arm[27:4] == 24'h12FFF1)
                        op.cls = zap_pkg::OP_BX;
                else if (arm[27:24] == 4'hF)
                        op.cls = zap_pkg::OP_SWI;
                else
                        op.cls = zap_pkg::OP_OTHER;
                op.cond   = arm[31:28];
                op.link   = (arm[27:25] == 3'b101) && arm[24];
                op.half   = half;
                op.offset = arm[23:0];
                op.rm     = arm[3:0];
                op.imm    = arm[23:0];
                op.word   = arm;
                return 1'b1;
        endfunction

        task automatic compare_op(input exp_op_t e);
                check_value("o_op_class", 32'(o_op_class), 32'(e.cls));
                // Fields of an undefined word carry no meaning.
                if (e.cls != zap_pkg::OP_UND)
                begin
                        check_value("o_op_cond", 32'(o_op_cond), 32'(e.cond));
                        check_value("o_op_link", 32'(o_op_link), 32'(e.link));
                        check_value("o_op_half", 32'(o_op_half), 32'(e.half));
                        check_value("o_op_offset", 32'(o_op_offset), 32'(e.offset));
                        check_value("o_op_rm", 32'(o_op_rm), 32'(e.rm));
                        check_value("o_op_imm", 32'(o_op_imm), 32'(e.imm));
                        check_value("o_op_word", o_op_word, e.word);
                end
        endtask

        // Sends one program segment and waits until the buffer has drained.
        task automatic run_segment(input logic thumb);
                int      idx;
                exp_op_t op;
                @(negedge i_clk);
                i_cpsr = {26'd0, thumb, 5'h13};
                idx    = 0;
                while (idx < seg_words.size() || fetch_credits != zap_pkg::FETCH_DEPTH)
                begin
                        @(negedge i_clk);
                        if (o_fetch_credit)
                        begin
                                fetch_credits++;
                                assert (fetch_credits <= zap_pkg::FETCH_DEPTH)
                                else fail_now("Fetch credit returned with no word outstanding");
                        end
                        if (idx < seg_words.size() && fetch_credits > 0)
                        begin
                                i_instr_valid = 1'b1;
                                i_instr       = seg_words[idx];
                                if (ref_decode(seg_words[idx], thumb, model_bl_hi, op))
                                        exp_q.push_back(op);
                                fetch_credits--;
                                words_sent++;
                                idx++;
                        end
                        else
                        begin
                                i_instr_valid = 1'b0;
                        end
                end
                seg_words.delete();
        endtask

        task automatic queue_word(input zap_pkg::instr_t w);
                seg_words.push_back(w);
                cycle_limit += 20;
        endtask

        // All fetch credits over the whole run, between segments too.
        always @(negedge i_clk)
        begin
                if (i_arst_n && o_fetch_credit)
                        credits_back++;
        end

        // Issue stage model that takes operations and hands credits back at random.
        always @(negedge i_clk)
        begin
                if (i_arst_n)
                begin
                        if (o_op_valid)
                        begin
                                assert (issue_credits != 0)
                                else fail_now("Operation presented while no issue credit was held");
                                assert (exp_q.size() != 0)
                                else fail_now("Operation presented with none expected");
                                issue_credits--;
                                compare_op(exp_q.pop_front());
                        end
                        i_issue_credit = 1'b0;
                        if (issue_credits < zap_pkg::ISSUE_CREDITS && ($random(seed) & 3) == 0)
                        begin
                                i_issue_credit = 1'b1;
                                issue_credits++;
                        end
                end
        end

        always @(posedge i_clk)
        begin
                cycles++;
                if (cycles >= cycle_limit)
                begin
                        $display("Timeout after %0d cycles with %0d operations outstanding",
                                 cycles, exp_q.size());
                        $display("RESULT: FAIL");
                        $fatal(1);
                end
        end

        initial
        begin
                i_clk          = 1'b0;
                i_arst_n       = 1'b0;
                i_instr_valid  = 1'b0;
                i_instr        = '0;
                i_cpsr         = 32'h13;
                i_issue_credit = 1'b0;
                model_bl_hi    = '0;
                fetch_credits  = zap_pkg::FETCH_DEPTH;
                issue_credits  = zap_pkg::ISSUE_CREDITS;
                words_sent     = 0;
                credits_back   = 0;
                cycles         = 0;
                cycle_limit    = 200 + 10;
                for (int i = 0; i < 32; i++)
                        rand_words[i] = $random(seed);
                repeat (10) @(negedge i_clk);
                i_arst_n = 1'b1;

                // ARM words: B, BL, BX, SWI, a conditional branch, random words.
                queue_word(32'hEA000010);
                queue_word(32'h0B123456);
                queue_word(32'hE12FFF13);
                queue_word(32'hEF00ABCD);
                queue_word(32'h1AFFFFFE);
                for (int i = 0; i < 12; i++)
                        queue_word(rand_words[i]);
                run_segment(1'b0);

                // Thumb branches, BL pairs, BX, SWI and undefined patterns.
                queue_word(32'hA5A5D005);
                queue_word(32'h0000D1F0);
                queue_word(32'h000023FF | 32'hC000);
                queue_word(32'h0000E400);
                queue_word(32'h0000F012);
                queue_word(32'h1234F834);
                queue_word(32'h0000F7FF);
                queue_word(32'h0000FFFE);
                queue_word(32'h00004770);
                queue_word(32'h00004708);
                queue_word(32'h0000DF42);
                queue_word(32'h00000000);
                queue_word(32'h00001C08);
                queue_word(32'h0000E800);
                run_segment(1'b1);

                for (int i = 12; i < 20; i++)
                        queue_word(rand_words[i]);
                run_segment(1'b0);

                for (int i = 20; i < 32; i++)
                        queue_word(rand_words[i]);
                run_segment(1'b1);

                while (exp_q.size() != 0)
                        @(negedge i_clk);
                repeat (4) @(negedge i_clk);
                assert (credits_back == words_sent)
                else fail_now($sformatf("Error: o_fetch_credit pulses got %h expected %h",
                                        credits_back, words_sent));
                $display("RESULT: PASS");
                $finish;
        end

endmodule

// ==== build.f ====
source/zap_pkg.sv
source/fetch_buffer.sv
source/decode_thumb.sv
source/decode_arm.sv
source/decode_frontend.sv
tests/decode_frontend_chk.sv
tests/decode_frontend_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the decode front-end testbench with Verilator and runs it.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f build.f \
        --top-module decode_frontend_tb -o decode_frontend_sim &&
./obj_dir/decode_frontend_sim ||
exit 1
